// ==== Makefile ====
# Verilator flow for the coreSlice decode/execute slice

VERILATOR ?= verilator
TOP       ?= coreSliceTb
RTL_TOP   ?= coreSlice
FILELIST  ?= coreSlice.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== coreSlice.f ====
source/pipePkg.sv
source/idExeBus.sv
source/regFile.sv
source/instrDecode.sv
source/exeReg.sv
source/execUnit.sv
source/coreSlice.sv
sim/coreSliceTb.sv

// ==== sim/coreSliceTb.sv ====
//~~~~~~~~~~~~~~~~~~~~
// coreSliceTb
// Testbench for the decode/execute slice. Random program
// generator, fetch model, reference model and result checker
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module coreSliceTb
    import pipePkg::*;
();

    localparam int          PROG_WORDS  = 64;
    localparam word_t       PROG_END    = PROG_WORDS * 4;
    localparam int unsigned SEED        = 98066;
    localparam int          TOTAL_INSTR = 5 * PROG_WORDS; // four programs plus an aborted one
    localparam int          CYCLE_LIMIT = 20 * TOTAL_INSTR + 100;

    typedef struct packed {
        word_t       pc;
        word_t       data;
        regAddr_t    dest;
        logic        write;
        exceptCode_t except;
        logic        taken;
        word_t       target;
    } refResult_t;

    logic        clk;
    logic        reset       = 1'b1;
    logic        instrValid  = 1'b0;
    logic        instrReady;
    word_t       instrPc     = '0;
    word_t       instr       = '0;
    logic        resultValid;
    logic        resultReady = 1'b0;
    word_t       resultPc;
    word_t       resultData;
    regAddr_t    resultDest;
    logic        resultWrite;
    exceptCode_t resultExcept;
    logic        redirectValid;
    word_t       redirectPc;

    word_t       progMem [PROG_WORDS];
    word_t       shadow [REG_COUNT];
    word_t       refPc;
    word_t       fetchPc;
    logic        running     = 1'b0;
    logic        randomReady = 1'b0;
    logic        prevReset   = 1'b0;
    logic        holdValid   = 1'b0;
    word_t       heldPc;
    word_t       heldData;
    logic [7:0]  heldMeta;
    int unsigned progState   = SEED;
    int unsigned readyState  = SEED;
    int          errorCount  = 0;
    int          checkCount  = 0;
    int          cycleCount;

    coreSlice UUT (
        .clk           (clk),
        .reset         (reset),
        .instrValid    (instrValid),
        .instrReady    (instrReady),
        .instrPc       (instrPc),
        .instr         (instr),
        .resultValid   (resultValid),
        .resultReady   (resultReady),
        .resultPc      (resultPc),
        .resultData    (resultData),
        .resultDest    (resultDest),
        .resultWrite   (resultWrite),
        .resultExcept  (resultExcept),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int unsigned lcg(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic checkValue(input string name, input word_t got, input word_t want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("MISMATCH time %0t %s: got %h, expected %h", $time, name, got, want);
        end
    endtask

    // expected outcome of one instruction against the shadow registers
    function automatic refResult_t refExec(input word_t pc, input word_t ins);
        refResult_t  res;
        word_t       a;
        word_t       b;
        word_t       sext;
        logic [32:0] wide;
        logic [5:0]  fn;
        a    = shadow[ins[25:21]];
        b    = shadow[ins[20:16]];
        sext = {{16{ins[15]}}, ins[15:0]};
        fn   = ins[5:0];
        wide = '0;
        res  = '0;
        res.pc     = pc;
        res.dest   = ins[20:16];
        res.write  = 1'b1;
        res.target = pc + 32'd4 + (sext << 2);
        case (ins[31:26])
            OP_SPECIAL: begin
                res.dest = ins[15:11];
                case (fn)
                    FN_ADDU, FN_ADD: res.data = a + b;
                    FN_SUBU, FN_SUB: res.data = a - b;
                    FN_AND:  res.data = a & b;
                    FN_OR:   res.data = a | b;
                    FN_XOR:  res.data = a ^ b;
                    FN_SLT:  res.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:  res.data = b << ins[10:6];
                    FN_SRL:  res.data = b >> ins[10:6];
                    default: res.except = EXC_RESERVED;
                endcase
                if (fn == FN_ADD) begin
                    wide = {a[31], a} + {b[31], b};
                end else if (fn == FN_SUB) begin
                    wide = {a[31], a} - {b[31], b};
                end
                if (wide[32] != wide[31]) begin
                    res.except = EXC_OVERFLOW; // 33-bit sign disagrees
                end
            end
            OP_ADDIU: res.data = a + sext;
            OP_ORI:   res.data = a | {16'h0000, ins[15:0]};
            OP_LUI:   res.data = {ins[15:0], 16'h0000};
            OP_BEQ:   res.taken = (a == b);
            OP_BNE:   res.taken = (a != b);
            default:  res.except = EXC_RESERVED;
        endcase
        if ((ins[31:26] == OP_BEQ) || (ins[31:26] == OP_BNE) || (res.except != EXC_NONE)) begin
            res.write = 1'b0;
            res.data  = '0;
        end
        return res;
    endfunction

    task automatic genProgram(input int regSpan);
        int unsigned r;
        int          kind;
        regAddr_t    rs;
        regAddr_t    rt;
        regAddr_t    rd;
        logic [15:0] imm;
        logic [5:0]  fnTable [10];
        fnTable = '{FN_ADDU, FN_ADD, FN_SUBU, FN_SUB, FN_AND,
                    FN_OR, FN_XOR, FN_SLT, FN_SLL, FN_SRL};
        for (int i = 0; i < PROG_WORDS; i++) begin
            progState = lcg(progState);
            r         = progState >> 8;
            kind      = int'(r % 16);
            rs        = regAddr_t'((r >> 4) % regSpan); // few registers give many hazards
            rt        = regAddr_t'((r >> 9) % regSpan);
            rd        = regAddr_t'((r >> 14) % regSpan);
            progState = lcg(progState);
            imm       = progState[31:16];
            case (kind)
                10: progMem[i] = {OP_ADDIU, rs, rt, imm};
                11: progMem[i] = {OP_ORI, rs, rt, imm};
                12: progMem[i] = {OP_LUI, 5'd0, rt, imm};
                13: progMem[i] = {OP_BEQ, rs, rt, 14'd0, imm[1:0]}; // short forward hop
                14: progMem[i] = {OP_BNE, rs, rt, 14'd0, imm[1:0]};
                15: begin
                    if (imm[15]) begin
                        progMem[i] = {6'h23, rs, rt, imm};
                    end else begin
                        progMem[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, 6'h3f};
                    end
                end
                default: progMem[i] = {OP_SPECIAL, rs, rt, rd, imm[4:0], fnTable[kind]};
            endcase
        end
    endtask

    // fetch model and ready generator
    always @(posedge clk) begin
        if (reset || !running) begin
            fetchPc = '0;
            instrValid <= 1'b0;
        end else begin
            if (redirectValid) begin
                fetchPc = redirectPc;
            end else if (instrValid && instrReady) begin
                fetchPc = fetchPc + 32'd4;
            end
            instrValid <= (fetchPc < PROG_END);
            instrPc    <= fetchPc;
            instr      <= progMem[fetchPc[7:2]];
        end
        if (randomReady) begin
            readyState = lcg(readyState);
            resultReady <= (readyState[31:30] != 2'b00); // 3 of 4 cycles
        end else begin
            resultReady <= 1'b1;
        end
    end

    // result checker sampled mid-cycle
    always @(negedge clk) begin
        refResult_t want;
        if (prevReset && !reset) begin
            checkValue("resultValid after reset", 32'(resultValid), 32'd0);
            checkValue("redirectValid after reset", 32'(redirectValid), 32'd0);
            checkValue("instrReady after reset", 32'(instrReady), 32'd1);
        end
        prevReset = reset;
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                shadow[i] = '0;
            end
        end
        if (reset || !running) begin
            refPc     = '0;
            holdValid = 1'b0;
        end else begin
            if (holdValid) begin
                checkValue("resultValid held", 32'(resultValid), 32'd1);
                checkValue("resultPc held", resultPc, heldPc);
                checkValue("resultData held", resultData, heldData);
                checkValue("result controls held",
                           32'({resultDest, resultWrite, resultExcept}), 32'(heldMeta));
            end
            holdValid = resultValid && !resultReady;
            if (holdValid) begin
                heldPc   = resultPc;
                heldData = resultData;
                heldMeta = {resultDest, resultWrite, resultExcept};
                checkValue("instrReady stalled", 32'(instrReady), 32'd0);
            end
            if (resultValid && resultReady) begin
                want = refExec(refPc, progMem[refPc[7:2]]);
                checkValue("resultPc", resultPc, want.pc);
                checkValue("resultExcept", 32'(resultExcept), 32'(want.except));
                checkValue("resultWrite", 32'(resultWrite), 32'(want.write));
                if (want.except == EXC_NONE) begin
                    checkValue("resultData", resultData, want.data);
                end
                if (want.write) begin
                    checkValue("resultDest", 32'(resultDest), 32'(want.dest));
                end
                checkValue("redirectValid", 32'(redirectValid), 32'(want.taken));
                if (want.taken) begin
                    checkValue("redirectPc", redirectPc, want.target);
                end
                if (want.write && (want.dest != '0)) begin
                    shadow[want.dest] = want.data;
                end
                refPc = want.taken ? want.target : refPc + 32'd4;
            end else begin
                checkValue("redirectValid idle", 32'(redirectValid), 32'd0);
            end
        end
    end

    task automatic resetDut();
        reset   <= 1'b1;
        running <= 1'b0;
        repeat (2) begin
            @(posedge clk);
        end
        reset <= 1'b0;
        @(posedge clk); // state checked on the negedge before this
    endtask

    task automatic runProgram(input string name, input logic randReady);
        int startErrors;
        startErrors = errorCount;
        @(posedge clk);
        running     <= 1'b1;
        randomReady <= randReady;
        @(posedge clk);
        while (refPc < PROG_END) begin
            @(posedge clk);
        end
        running     <= 1'b0;
        randomReady <= 1'b0;
        $display("test %s: %0d errors", name, errorCount - startErrors);
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        resetDut();
        $display("test reset state: %0d errors", errorCount);
        genProgram(4);
        runProgram("dependence chains", 1'b0);
        genProgram(8);
        runProgram("alu, immediates, exceptions and branches", 1'b0);
        genProgram(8);
        runProgram("back-pressure", 1'b1);
        genProgram(32);
        @(posedge clk);
        running     <= 1'b1;
        randomReady <= 1'b1;
        repeat (40) begin
            @(posedge clk);
        end
        resetDut(); // abort the program midway
        for (int i = 0; i < PROG_WORDS; i++) begin
            progMem[i] = {OP_ORI, regAddr_t'(i), regAddr_t'(i), 16'(i)}; // r[i] | i
        end
        runProgram("mid-run reset, register readback", 1'b1);
        $display("done: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/coreSlice.sv ====
//~~~~~~~~~~~~~~~~~~~~
// coreSlice
// Decode and execute slice of the pipeline: decoder, ID/EXE
// register, execute unit and register file
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module coreSlice
    import pipePkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        instrValid,
    output logic             instrReady,
    input  wire word_t       instrPc,
    input  wire word_t       instr,
    output logic             resultValid,
    input  wire logic        resultReady,
    output word_t            resultPc,
    output word_t            resultData,
    output regAddr_t         resultDest,
    output logic             resultWrite,
    output exceptCode_t      resultExcept,
    output logic             redirectValid,
    output word_t            redirectPc
);

    regAddr_t readAddrA;
    regAddr_t readAddrB;
    word_t    readDataA;
    word_t    readDataB;
    logic     wbEn;
    regAddr_t wbAddr;
    word_t    wbData;

    idExeBus idBus ();
    idExeBus exBus ();

    instrDecode decode (
        .instrValid (instrValid),
        .instrPc    (instrPc),
        .instr      (instr),
        .readAddrA  (readAddrA),
        .readAddrB  (readAddrB),
        .readDataA  (readDataA),
        .readDataB  (readDataB),
        .idBus      (idBus.producer)
    );

    exeReg pipeReg (
        .clk         (clk),
        .reset       (reset),
        .resultReady (resultReady),
        .flush       (redirectValid), // drop the wrong-path fetch
        .advance     (instrReady),
        .idBus       (idBus.consumer),
        .exBus       (exBus.producer)
    );

    execUnit execute (
        .exBus         (exBus.consumer),
        .resultReady   (resultReady),
        .resultValid   (resultValid),
        .resultPc      (resultPc),
        .resultData    (resultData),
        .resultDest    (resultDest),
        .resultWrite   (resultWrite),
        .resultExcept  (resultExcept),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .wbEn          (wbEn),
        .wbAddr        (wbAddr),
        .wbData        (wbData)
    );

    regFile regs (
        .clk       (clk),
        .reset     (reset),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .writeEn   (wbEn),
        .writeAddr (wbAddr),
        .writeData (wbData)
    );

endmodule

`default_nettype wire

// ==== source/exeReg.sv ====
//~~~~~~~~~~~~~~~~~~~~
// exeReg
// ID/EXE pipeline register. Holds the decoded bundle under
// back-pressure, clears it on reset or a branch flush
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module exeReg (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic resultReady,
    input  wire logic flush,
    output logic      advance,
    idExeBus.consumer idBus,
    idExeBus.producer exBus
);

    // empty stage, or its result leaves this cycle
    assign advance = !exBus.valid || resultReady;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            exBus.valid        <= 1'b0;
            exBus.pc           <= '0;
            exBus.opA          <= '0;
            exBus.opB          <= '0;
            exBus.imm          <= '0;
            exBus.useImm       <= 1'b0;
            exBus.shamt        <= '0;
            exBus.aluOp        <= '0;
            exBus.dest         <= '0;
            exBus.writeEn      <= 1'b0;
            exBus.isBranch     <= 1'b0;
            exBus.branchNe     <= 1'b0;
            exBus.overflowTrap <= 1'b0;
            exBus.except       <= '0;
        end else if (advance) begin
            exBus.valid        <= idBus.valid;
            exBus.pc           <= idBus.pc;
            exBus.opA          <= idBus.opA;
            exBus.opB          <= idBus.opB;
            exBus.imm          <= idBus.imm;
            exBus.useImm       <= idBus.useImm;
            exBus.shamt        <= idBus.shamt;
            exBus.aluOp        <= idBus.aluOp;
            exBus.dest         <= idBus.dest;
            exBus.writeEn      <= idBus.writeEn;
            exBus.isBranch     <= idBus.isBranch;
            exBus.branchNe     <= idBus.branchNe;
            exBus.overflowTrap <= idBus.overflowTrap;
            exBus.except       <= idBus.except;
        end
    end

endmodule

`default_nettype wire

// ==== source/execUnit.sv ====
//~~~~~~~~~~~~~~~~~~~~
// execUnit
// ALU, branch compare and overflow check. Produces one result
// record per instruction, the register writeback and the
// redirect for taken branches
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module execUnit
    import pipePkg::*;
(
    idExeBus.consumer    exBus,
    input  wire logic    resultReady,
    output logic         resultValid,
    output word_t        resultPc,
    output word_t        resultData,
    output regAddr_t     resultDest,
    output logic         resultWrite,
    output exceptCode_t  resultExcept,
    output logic         redirectValid,
    output word_t        redirectPc,
    output logic         wbEn,
    output regAddr_t     wbAddr,
    output word_t        wbData
);

    word_t       aluB;
    word_t       sum;
    word_t       diff;
    word_t       aluResult;
    logic        sltBit;
    logic        addOvf;
    logic        subOvf;
    logic        overflow;
    logic        operandsEqual;
    logic        taken;
    logic        transfer;
    exceptCode_t exceptOut;

    assign aluB   = exBus.useImm ? exBus.imm : exBus.opB;
    assign sum    = exBus.opA + aluB;
    assign diff   = exBus.opA - aluB;
    assign sltBit = $signed(exBus.opA) < $signed(aluB);

    // signed overflow: operand signs vs result sign
    assign addOvf = (exBus.opA[31] == aluB[31]) && (sum[31] != exBus.opA[31]);
    assign subOvf = (exBus.opA[31] != aluB[31]) && (diff[31] != exBus.opA[31]);

    always_comb begin
        case (exBus.aluOp)
            ALU_ADD: aluResult = sum;
            ALU_SUB: aluResult = diff;
            ALU_AND: aluResult = exBus.opA & aluB;
            ALU_OR:  aluResult = exBus.opA | aluB;
            ALU_XOR: aluResult = exBus.opA ^ aluB;
            ALU_SLT: aluResult = {31'b0, sltBit};
            ALU_SLL: aluResult = exBus.opB << exBus.shamt;
            ALU_SRL: aluResult = exBus.opB >> exBus.shamt; // logical
            ALU_LUI: aluResult = exBus.imm;
            default: aluResult = '0;
        endcase
    end

    assign overflow = exBus.overflowTrap &&
                      ((exBus.aluOp == ALU_SUB) ? subOvf : addOvf);

    always_comb begin
        if (exBus.except != EXC_NONE) begin
            exceptOut = exBus.except;
        end else if (overflow) begin
            exceptOut = EXC_OVERFLOW;
        end else begin
            exceptOut = EXC_NONE;
        end
    end

    assign operandsEqual = (exBus.opA == exBus.opB);
    assign taken         = exBus.isBranch && (operandsEqual != exBus.branchNe);
    assign transfer      = exBus.valid && resultReady;

    assign resultValid  = exBus.valid;
    assign resultPc     = exBus.pc;
    assign resultData   = (exBus.isBranch || (exceptOut != EXC_NONE)) ? '0 : aluResult;
    assign resultDest   = exBus.dest;
    assign resultWrite  = exBus.writeEn && (exceptOut == EXC_NONE);
    assign resultExcept = exceptOut;

    assign redirectValid = transfer && taken;
    assign redirectPc    = exBus.imm; // branch target from decode

    assign wbEn   = transfer && resultWrite;
    assign wbAddr = exBus.dest;
    assign wbData = resultData;

endmodule

`default_nettype wire

// ==== source/idExeBus.sv ====
//~~~~~~~~~~~~~~~~~~~~
// idExeBus
// One decoded instruction bundle passed between pipeline stages
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface idExeBus
    import pipePkg::*;
();

    logic        valid;
    word_t       pc;
    word_t       opA;
    word_t       opB;
    word_t       imm;          // extended, or branch target
    logic        useImm;
    shamt_t      shamt;
    aluOp_t      aluOp;
    regAddr_t    dest;
    logic        writeEn;
    logic        isBranch;
    logic        branchNe;
    logic        overflowTrap; // ADD or SUB
    exceptCode_t except;

    modport producer (
        output valid, pc, opA, opB, imm, useImm, shamt, aluOp,
               dest, writeEn, isBranch, branchNe, overflowTrap, except
    );

    modport consumer (
        input valid, pc, opA, opB, imm, useImm, shamt, aluOp,
              dest, writeEn, isBranch, branchNe, overflowTrap, except
    );

endinterface

`default_nettype wire

// ==== source/instrDecode.sv ====
//~~~~~~~~~~~~~~~~~~~~
// instrDecode
// Cracks an instruction into operands and controls: register
// read, immediate extension, destination select, branch target
// and reserved-instruction detection
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module instrDecode
    import pipePkg::*;
(
    input  wire logic     instrValid,
    input  wire word_t    instrPc,
    input  wire word_t    instr,
    output regAddr_t      readAddrA,
    output regAddr_t      readAddrB,
    input  wire word_t    readDataA,
    input  wire word_t    readDataB,
    idExeBus.producer     idBus
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    regAddr_t    rs;
    regAddr_t    rt;
    regAddr_t    rd;
    shamt_t      shamt;
    logic [15:0] imm16;

    word_t       signExt;
    word_t       zeroExt;
    word_t       upperImm;
    word_t       branchTarget;

    word_t       immSel;
    aluOp_t      aluOp;
    regAddr_t    dest;
    logic        useImm;
    logic        writeEn;
    logic        isBranch;
    logic        branchNe;
    logic        overflowTrap;
    exceptCode_t except;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];

    assign signExt      = {{16{imm16[15]}}, imm16};
    assign zeroExt      = {16'b0, imm16};
    assign upperImm     = {imm16, 16'b0};
    assign branchTarget = instrPc + 32'd4 + {signExt[29:0], 2'b00};

    always_comb begin
        aluOp        = ALU_ADD;
        immSel       = signExt;
        dest         = rt;  // I-type default
        useImm       = 1'b0;
        writeEn      = 1'b0;
        isBranch     = 1'b0;
        branchNe     = 1'b0;
        overflowTrap = 1'b0;
        except       = EXC_NONE;
        case (opcode)
            OP_SPECIAL: begin
                dest    = rd;
                writeEn = 1'b1;
                case (funct)
                    FN_ADD: begin
                        overflowTrap = 1'b1;
                    end
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUB: begin
                        aluOp        = ALU_SUB;
                        overflowTrap = 1'b1;
                    end
                    FN_SUBU: aluOp  = ALU_SUB;
                    FN_AND:  aluOp  = ALU_AND;
                    FN_OR:   aluOp  = ALU_OR;
                    FN_XOR:  aluOp  = ALU_XOR;
                    FN_SLT:  aluOp  = ALU_SLT;
                    FN_SLL:  aluOp  = ALU_SLL;
                    FN_SRL:  aluOp  = ALU_SRL;
                    default: except = EXC_RESERVED;
                endcase
            end
            OP_ADDIU: begin
                useImm  = 1'b1;
                writeEn = 1'b1;
            end
            OP_ORI: begin
                aluOp   = ALU_OR;
                immSel  = zeroExt;
                useImm  = 1'b1;
                writeEn = 1'b1;
            end
            OP_LUI: begin
                aluOp   = ALU_LUI;
                immSel  = upperImm;
                useImm  = 1'b1;
                writeEn = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                immSel   = branchTarget; // target rides in imm
                isBranch = 1'b1;
                branchNe = (opcode == OP_BNE);
            end
            default: except = EXC_RESERVED;
        endcase
        if (except != EXC_NONE) begin
            writeEn = 1'b0;
        end
    end

    assign readAddrA = rs;
    assign readAddrB = rt;

    assign idBus.valid        = instrValid;
    assign idBus.pc           = instrPc;
    assign idBus.opA          = readDataA;
    assign idBus.opB          = readDataB;
    assign idBus.imm          = immSel;
    assign idBus.useImm       = useImm;
    assign idBus.shamt        = shamt;
    assign idBus.aluOp        = aluOp;
    assign idBus.dest         = dest;
    assign idBus.writeEn      = writeEn;
    assign idBus.isBranch     = isBranch;
    assign idBus.branchNe     = branchNe;
    assign idBus.overflowTrap = overflowTrap;
    assign idBus.except       = except;

endmodule

`default_nettype wire

// ==== source/pipePkg.sv ====
//~~~~~~~~~~~~~~~~~~~~
// pipePkg
// Shared widths, ALU operation codes, MIPS opcode and funct
// encodings and exception codes for the decode/execute slice
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package pipePkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [3:0]  aluOp_t;
    typedef logic [1:0]  exceptCode_t;

    localparam int REG_COUNT = 32;

    // ALU operations
    localparam aluOp_t ALU_ADD = 4'd0;
    localparam aluOp_t ALU_SUB = 4'd1;
    localparam aluOp_t ALU_AND = 4'd2;
    localparam aluOp_t ALU_OR  = 4'd3;
    localparam aluOp_t ALU_XOR = 4'd4;
    localparam aluOp_t ALU_SLT = 4'd5; // signed compare
    localparam aluOp_t ALU_SLL = 4'd6;
    localparam aluOp_t ALU_SRL = 4'd7;
    localparam aluOp_t ALU_LUI = 4'd8; // passes the shifted immediate

    localparam exceptCode_t EXC_NONE     = 2'd0;
    localparam exceptCode_t EXC_OVERFLOW = 2'd1;
    localparam exceptCode_t EXC_RESERVED = 2'd2;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // SPECIAL funct field, instr[5:0]
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

`default_nettype wire

// ==== source/regFile.sv ====
//~~~~~~~~~~~~~~~~~~~~
// regFile
// 32 x 32 register file with two read ports and one write port.
// r0 reads as zero and a read of the register being written
// returns the new value in the same cycle
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module regFile
    import pipePkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire regAddr_t readAddrA,
    input  wire regAddr_t readAddrB,
    output word_t         readDataA,
    output word_t         readDataB,
    input  wire logic     writeEn,
    input  wire regAddr_t writeAddr,
    input  wire word_t    writeData
);

    word_t regs [REG_COUNT];

    function automatic word_t readPort(input regAddr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (writeEn && (writeAddr == addr)) begin
            data = writeData; // bypass
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    always_comb begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end

endmodule

`default_nettype wire
